// File: hw/regFilePkg.sv
// ####################
// register file numbering
// value, immediate and identifier types
// special register codes
// ####################

package regFilePkg;

	// register and immediate widths
	localparam int regWidth = 64;
	localparam int immWidth = 33;	// bit 32 is the sign

	localparam int gprCount = 32;
	localparam int regIdWidth = 6;
	localparam int gprIdxWidth = $clog2(gprCount);	// low bits select a bank entry

	typedef logic [regIdWidth-1:0] regId;
	typedef logic [regWidth-1:0] regValue;
	typedef logic [immWidth-1:0] immValue;

	// identifier map
	//   0..31   general registers
	//   32..34  DLR, DHR, SP
	//   35..61  reserved, read as zero and never written
	//   62      lane immediate
	//   63      zero register, also the "no write" destination
	localparam regId regIdDlr = 6'd32;
	localparam regId regIdDhr = 6'd33;
	localparam regId regIdSp = 6'd34;

	localparam regId regIdImm = 6'd62;	// pseudo-source, constant
	localparam regId regIdZzr = 6'd63;	// pseudo-source, constant

endpackage

// File: hw/pipePkg.sv
// ####################
// pipeline-side types
// lane and stage writes, read port vectors
// ####################

package pipePkg;

	localparam int laneCount = 3;
	localparam int readPortCount = 6;	// two per lane

	// which bank holds the newest copy of a register
	typedef logic [$clog2(laneCount)-1:0] laneSel;

	// one lane's writeback, 70 bits
	typedef struct packed {
		regFilePkg::regId dest;
		regFilePkg::regValue value;
	} laneWrite;

	// index 0 is lane A, 2 is lane C
	typedef laneWrite [laneCount-1:0] stageWrites;

	typedef regFilePkg::regId [readPortCount-1:0] readIdVec;
	typedef regFilePkg::regValue [readPortCount-1:0] readValVec;

	// immediate per lane, ports 2i and 2i+1 share lane i
	typedef regFilePkg::immValue [laneCount-1:0] immLaneVec;

	typedef struct packed {
		regFilePkg::regValue dlr;
		regFilePkg::regValue dhr;
		regFilePkg::regValue sp;
	} sprVec;

endpackage

// File: hw/gprBankLvt.sv
// ####################
// GPR banks with live-value table
// one bank per write lane, six lookups
// ####################

`timescale 1ns/1ps

module gprBankLvt (
	input logic clock,
	input logic rstN,
	input logic writeEnable,
	input pipePkg::stageWrites stage,	// EX3 writeback
	input pipePkg::readIdVec lookupIds,
	output pipePkg::readValVec lookupVals
);

	// banks[lane][reg], each lane only ever writes its own bank
	regFilePkg::regValue banks [pipePkg::laneCount][regFilePkg::gprCount];

	// newest bank per register
	pipePkg::laneSel liveTable [regFilePkg::gprCount];

	logic [pipePkg::laneCount-1:0] laneHitsGpr;

	always_comb
	begin
		for (int l = 0; l < pipePkg::laneCount; l++)
		begin
			laneHitsGpr[l] = (stage[l].dest < regFilePkg::gprCount);
		end
	end

	// write side
	// lanes are walked A to C so the live entry ends up on the
	// highest lane that hit the register this cycle
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int r = 0; r < regFilePkg::gprCount; r++)
			begin
				liveTable[r] <= '0;
				for (int l = 0; l < pipePkg::laneCount; l++)
				begin
					banks[l][r] <= '0;
				end
			end
		end
		else if (writeEnable)
		begin
			for (int l = 0; l < pipePkg::laneCount; l++)
			begin
				if (laneHitsGpr[l])
				begin
					banks[l][stage[l].dest[regFilePkg::gprIdxWidth-1:0]] <= stage[l].value;
					liveTable[stage[l].dest[regFilePkg::gprIdxWidth-1:0]] <=
						pipePkg::laneSel'(l);
				end
			end
		end
	end

	// lookup side, purely combinational
	// the read port decides whether the id is really a GPR
	always_comb
	begin
		logic [regFilePkg::gprIdxWidth-1:0] idx;
		pipePkg::laneSel sel;

		for (int p = 0; p < pipePkg::readPortCount; p++)
		begin
			idx = lookupIds[p][regFilePkg::gprIdxWidth-1:0];
			sel = liveTable[idx];
			lookupVals[p] = banks[sel][idx];
		end
	end

endmodule

// File: hw/specialRegs.sv
// ####################
// DLR, DHR and SP
// outside reload unless writeback hits
// ####################

`timescale 1ns/1ps

module specialRegs (
	input logic clock,
	input logic rstN,
	input logic writeEnable,
	input pipePkg::stageWrites stage,	// EX3 writeback
	input pipePkg::sprVec sprIn,
	output pipePkg::sprVec sprOut
);

	// next value for one special register
	// later lanes overwrite earlier ones, so C beats B beats A
	function automatic regFilePkg::regValue sprNext(
		input regFilePkg::regId code,
		input pipePkg::stageWrites wr,
		input regFilePkg::regValue outside
	);
		regFilePkg::regValue nxt;

		nxt = outside;
		for (int l = 0; l < pipePkg::laneCount; l++)
		begin
			if (wr[l].dest == code)
				nxt = wr[l].value;
		end
		return nxt;
	endfunction

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			sprOut <= '0;
		end
		else if (writeEnable)	// frozen on hold or EX3 flush
		begin
			sprOut.dlr <= sprNext(regFilePkg::regIdDlr, stage, sprIn.dlr);
			sprOut.dhr <= sprNext(regFilePkg::regIdDhr, stage, sprIn.dhr);
			sprOut.sp <= sprNext(regFilePkg::regIdSp, stage, sprIn.sp);
		end
	end

endmodule

// File: hw/readPort.sv
// ####################
// one read port
// source decode, then EX1..EX3 forwarding
// ####################

`timescale 1ns/1ps

module readPort (
	input regFilePkg::regId regIdIn,
	input regFilePkg::regValue gprValue,	// from the live-value lookup
	input pipePkg::sprVec sprVals,
	input regFilePkg::immValue imm,	// this port's lane immediate
	input pipePkg::stageWrites ex1,
	input pipePkg::stageWrites ex2,
	input pipePkg::stageWrites ex3,
	output regFilePkg::regValue value
);

	regFilePkg::regValue baseValue;
	logic isConst;

	// forward from one stage
	// walked C down to A so that lane A wins inside the stage
	function automatic regFilePkg::regValue fwdStage(
		input pipePkg::stageWrites st,
		input regFilePkg::regId id,
		input regFilePkg::regValue older
	);
		regFilePkg::regValue v;

		v = older;
		for (int l = pipePkg::laneCount - 1; l >= 0; l--)
		begin
			if (st[l].dest == id)
				v = st[l].value;
		end
		return v;
	endfunction

	// source decode
	always_comb
	begin
		isConst = 1'b0;
		baseValue = '0;
		if (regIdIn < regFilePkg::gprCount)
		begin
			baseValue = gprValue;
		end
		else
		begin
			case (regIdIn)
				regFilePkg::regIdDlr: baseValue = sprVals.dlr;
				regFilePkg::regIdDhr: baseValue = sprVals.dhr;
				regFilePkg::regIdSp: baseValue = sprVals.sp;
				regFilePkg::regIdImm:
				begin
					// sign from bit 32
					baseValue = {{(regFilePkg::regWidth - regFilePkg::immWidth){imm[32]}}, imm};
					isConst = 1'b1;
				end
				regFilePkg::regIdZzr:
				begin
					baseValue = '0;
					isConst = 1'b1;
				end
				default: baseValue = '0;	// reserved codes
			endcase
		end
	end

	// forwarding, youngest stage applied last so EX1 wins
	always_comb
	begin
		if (isConst)
		begin
			value = baseValue;	// immediates and zero never forward
		end
		else
		begin
			value = fwdStage(ex1, regIdIn,
				fwdStage(ex2, regIdIn,
				fwdStage(ex3, regIdIn, baseValue)));
		end
	end

endmodule

// File: hw/regFileTop.sv
// ####################
// three-lane register file
// 32 GPRs, six read ports, three write lanes
// ####################

`timescale 1ns/1ps

module regFileTop (
	input logic clock,
	input logic rstN,
	input logic hold,
	input pipePkg::readIdVec readIds,
	input pipePkg::immLaneVec immLanes,
	input pipePkg::stageWrites exStage1,
	input pipePkg::stageWrites exStage2,
	input pipePkg::stageWrites exStage3,	// also the writeback stage
	input logic ex3Flush,
	input pipePkg::sprVec sprIn,
	output pipePkg::readValVec readVals,
	output pipePkg::sprVec sprOut
);

	logic writeEnable;
	pipePkg::readValVec bankVals;	// raw live-value lookups

	// stall or a flushed EX3 blocks every write
	assign writeEnable = !hold && !ex3Flush;

	gprBankLvt u_gprBankLvt (
		.clock(clock),
		.rstN(rstN),
		.writeEnable(writeEnable),
		.stage(exStage3),
		.lookupIds(readIds),
		.lookupVals(bankVals)
	);

	specialRegs u_specialRegs (
		.clock(clock),
		.rstN(rstN),
		.writeEnable(writeEnable),
		.stage(exStage3),
		.sprIn(sprIn),
		.sprOut(sprOut)
	);

	// ports 0,1 on lane A, 2,3 on lane B, 4,5 on lane C
	for (genvar i = 0; i < pipePkg::readPortCount; i++)
	begin : readPortGen
		readPort u_readPort (
			.regIdIn(readIds[i]),
			.gprValue(bankVals[i]),
			.sprVals(sprOut),
			.imm(immLanes[i / 2]),
			.ex1(exStage1),
			.ex2(exStage2),
			.ex3(exStage3),
			.value(readVals[i])
		);
	end

endmodule

// File: dv/regFileProperties.sv
// ####################
// GPR bank and live table checks
// bound into gprBankLvt
// ####################

`timescale 1ns/1ps

module regFileProperties (
	input logic clock,
	input logic rstN,
	input logic writeEnable,
	input pipePkg::stageWrites stage,
	input pipePkg::laneSel liveTable [regFilePkg::gprCount],
	input regFilePkg::regValue banks [pipePkg::laneCount][regFilePkg::gprCount]
);

	// flat copies so $stable sees one vector
	logic [2*regFilePkg::gprCount-1:0] liveFlat;
	logic [pipePkg::laneCount*regFilePkg::gprCount*regFilePkg::regWidth-1:0] bankFlat;

	int failCount = 0;	// failed assertions so far

	always_comb
	begin
		for (int r = 0; r < regFilePkg::gprCount; r++)
		begin
			liveFlat[r*2 +: 2] = liveTable[r];
			for (int l = 0; l < pipePkg::laneCount; l++)
			begin
				bankFlat[(l*regFilePkg::gprCount + r)*regFilePkg::regWidth +: regFilePkg::regWidth]
					= banks[l][r];
			end
		end
	end

	// no write enable, no state change
	assert property (@(posedge clock) disable iff (!rstN) !writeEnable |=> $stable(liveFlat))
	else
	begin
		$error("live table changed while writes were blocked");
		failCount++;
	end

	assert property (@(posedge clock) disable iff (!rstN) !writeEnable |=> $stable(bankFlat))
	else
	begin
		$error("GPR bank changed while writes were blocked");
		failCount++;
	end

	// lane C always owns the newest copy of its register
	assert property (@(posedge clock) disable iff (!rstN)
		writeEnable && (stage[2].dest < regFilePkg::gprCount)
		|=> liveTable[$past(stage[2].dest[4:0])] == pipePkg::laneSel'(2))
	else
	begin
		$error("lane C write did not leave the live entry on bank C");
		failCount++;
	end

endmodule

bind gprBankLvt regFileProperties u_regFileProperties (
	.clock(clock),
	.rstN(rstN),
	.writeEnable(writeEnable),
	.stage(stage),
	.liveTable(liveTable),
	.banks(banks)
);

// File: dv/regFileTb.sv
// ####################
// register file testbench
// random lane traffic, model compare, report
// ####################

`timescale 1ns/1ps

module regFileTb;

	localparam int clockPeriod = 8;
	localparam int resetCycles = 10;

	// test modes
	localparam int modeWrite = 1;
	localparam int modeConst = 2;
	localparam int modeForward = 3;
	localparam int modeHoldFlush = 4;
	localparam int modeSpecial = 5;

	// test lengths in cycles
	localparam int writeCycles = 200;
	localparam int constCycles = 60;
	localparam int forwardCycles = 120;
	localparam int holdFlushCycles = 100;
	localparam int specialCycles = 80;
	localparam int testCycles = writeCycles + constCycles + forwardCycles
		+ holdFlushCycles + specialCycles + resetCycles + 1;
	localparam int cycleLimit = testCycles * 3 / 2;	// 50 percent margin

	logic clock;
	logic rstN;
	logic hold;
	logic ex3Flush;
	pipePkg::readIdVec readIds;
	pipePkg::immLaneVec immLanes;
	pipePkg::stageWrites exStage1;
	pipePkg::stageWrites exStage2;
	pipePkg::stageWrites exStage3;
	pipePkg::sprVec sprIn;
	pipePkg::readValVec readVals;
	pipePkg::sprVec sprOut;

	// reference state
	regFilePkg::regValue modelGpr [regFilePkg::gprCount];
	pipePkg::sprVec modelSpr;

	string testName = "reset";
	int testErrors = 0;
	int totalErrors = 0;
	int checkCount = 0;
	int testCount = 0;
	int cycleCount = 0;

	regFileTop u_regFileTop (
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.readIds(readIds),
		.immLanes(immLanes),
		.exStage1(exStage1),
		.exStage2(exStage2),
		.exStage3(exStage3),
		.ex3Flush(ex3Flush),
		.sprIn(sprIn),
		.sprOut(sprOut),
		.readVals(readVals)
	);

	initial
	begin
		clock = 1'b0;
		forever
		begin
			#(clockPeriod / 2) clock = ~clock;
		end
	end

	// expected read for one port from the model
	function automatic regFilePkg::regValue expectedRead(
		input regFilePkg::regId id,
		input regFilePkg::immValue imm
	);
		pipePkg::stageWrites stages [3];
		regFilePkg::regValue base;

		if (id == regFilePkg::regIdImm)
			return regFilePkg::regValue'(signed'(imm));	// constant, no forward
		if (id == regFilePkg::regIdZzr)
			return '0;
		if (id < regFilePkg::gprCount)
			base = modelGpr[id[4:0]];
		else if (id == regFilePkg::regIdDlr)
			base = modelSpr.dlr;
		else if (id == regFilePkg::regIdDhr)
			base = modelSpr.dhr;
		else if (id == regFilePkg::regIdSp)
			base = modelSpr.sp;
		else
			base = '0;	// reserved codes
		stages[0] = exStage1;
		stages[1] = exStage2;
		stages[2] = exStage3;
		// youngest stage first, lane A first, first hit wins
		for (int s = 0; s < 3; s++)
		begin
			for (int l = 0; l < pipePkg::laneCount; l++)
			begin
				if (stages[s][l].dest == id)
					return stages[s][l].value;
			end
		end
		return base;
	endfunction

	task automatic reportMismatch(
		input string what,
		input regFilePkg::regValue expVal,
		input regFilePkg::regValue actVal
	);
		$display("[FAIL] %s %s: expected %h, actual %h", testName, what, expVal, actVal);
		testErrors++;
		totalErrors++;
	endtask

	task automatic checkOutputs();
		regFilePkg::regValue expVal;

		for (int p = 0; p < pipePkg::readPortCount; p++)
		begin
			expVal = expectedRead(readIds[p], immLanes[p / 2]);
			checkCount++;
			if (readVals[p] !== expVal)
				reportMismatch($sformatf("read port %0d id %0d", p, readIds[p]),
					expVal, readVals[p]);
		end
		checkCount += 3;
		if (sprOut.dlr !== modelSpr.dlr)
			reportMismatch("DLR", modelSpr.dlr, sprOut.dlr);
		if (sprOut.dhr !== modelSpr.dhr)
			reportMismatch("DHR", modelSpr.dhr, sprOut.dhr);
		if (sprOut.sp !== modelSpr.sp)
			reportMismatch("SP", modelSpr.sp, sprOut.sp);
	endtask

	// what the coming edge stores, later lanes overwrite earlier ones
	task automatic updateModel();
		pipePkg::sprVec nextSpr;

		if (!hold && !ex3Flush)
		begin
			nextSpr = sprIn;
			for (int l = 0; l < pipePkg::laneCount; l++)
			begin
				if (exStage3[l].dest < regFilePkg::gprCount)
					modelGpr[exStage3[l].dest[4:0]] = exStage3[l].value;
				if (exStage3[l].dest == regFilePkg::regIdDlr)
					nextSpr.dlr = exStage3[l].value;
				if (exStage3[l].dest == regFilePkg::regIdDhr)
					nextSpr.dhr = exStage3[l].value;
				if (exStage3[l].dest == regFilePkg::regIdSp)
					nextSpr.sp = exStage3[l].value;
			end
			modelSpr = nextSpr;
		end
	endtask

	// compare 1 ns before each edge, inputs are settled by then
	initial
	begin
		forever
		begin
			@(posedge clock);
			#(clockPeriod - 1);
			if (rstN)
			begin
				checkOutputs();
				updateModel();
			end
		end
	end

	always @(posedge clock)
		cycleCount <= cycleCount + 1;

	initial
	begin
		wait (cycleCount >= cycleLimit);
		$display("timeout: run did not finish within %0d cycles", cycleLimit);
		$display("*** FAILED ***");
		$finish;
	end

	function automatic regFilePkg::regValue randomValue();
		return {$urandom, $urandom};
	endfunction

	function automatic regFilePkg::regId pickDest(input int mode);
		int r;

		r = $urandom % 5;
		case (mode)
			modeWrite: return (r == 0) ? regFilePkg::regIdZzr : regFilePkg::regId'($urandom % 8);
			modeConst:
			begin
				if (r < 2)
					return regFilePkg::regIdImm;
				if (r < 4)
					return regFilePkg::regIdZzr;
				return regFilePkg::regId'($urandom % 32);
			end
			modeForward: return regFilePkg::regId'($urandom % 4);	// heavy overlap
			modeSpecial:
			begin
				if (r == 4)
					return regFilePkg::regId'($urandom % 32);
				return (r == 3) ? regFilePkg::regIdZzr : regFilePkg::regId'(32 + r);
			end
			default: return regFilePkg::regId'($urandom % 8);
		endcase
	endfunction

	function automatic regFilePkg::regId pickRead(input int mode);
		int r;

		r = $urandom % 3;
		case (mode)
			modeWrite: return regFilePkg::regId'($urandom % 8);
			modeConst:
			begin
				if (r == 0)
					return regFilePkg::regIdImm;
				if (r == 1)
					return regFilePkg::regIdZzr;
				return regFilePkg::regId'(35 + $urandom % 27);	// reserved range
			end
			modeForward: return regFilePkg::regId'($urandom % 4);
			modeSpecial: return regFilePkg::regId'(32 + r);
			default: return regFilePkg::regId'($urandom % 8);
		endcase
	endfunction

	// one cycle of stimulus, starts on a rising edge and ends on the next
	task automatic driveCycle(input int mode);
		#1;
		hold = (mode == modeHoldFlush) ? ($urandom % 2 == 0) : 1'b0;
		ex3Flush = (mode == modeHoldFlush) ? ($urandom % 3 == 0) : 1'b0;
		if (mode == modeSpecial)
			hold = ($urandom % 8 == 0);
		for (int l = 0; l < pipePkg::laneCount; l++)
		begin
			immLanes[l] = regFilePkg::immValue'(randomValue());
			exStage1[l].dest = (mode == modeWrite) ? regFilePkg::regIdZzr : pickDest(mode);
			exStage2[l].dest = (mode == modeWrite) ? regFilePkg::regIdZzr : pickDest(mode);
			exStage3[l].dest = pickDest(mode);
			exStage1[l].value = randomValue();
			exStage2[l].value = randomValue();
			exStage3[l].value = randomValue();
		end
		sprIn = {randomValue(), randomValue(), randomValue()};
		for (int p = 0; p < pipePkg::readPortCount; p++)
		begin
			readIds[p] = pickRead(mode);
		end
		@(posedge clock);
	endtask

	task automatic runTest(input string name, input int mode, input int cycles);
		testName = name;
		testErrors = 0;
		for (int c = 0; c < cycles; c++)
		begin
			driveCycle(mode);
		end
		$display("test %s: %0d cycles, %0d errors", name, cycles, testErrors);
		testCount++;
	endtask

	initial
	begin
		void'($urandom(32'h7bfe_3089));
		rstN = 1'b0;
		hold = 1'b0;
		ex3Flush = 1'b0;
		readIds = '0;
		immLanes = '0;
		sprIn = '0;
		modelSpr = '0;
		for (int l = 0; l < pipePkg::laneCount; l++)
		begin
			exStage1[l] = {regFilePkg::regIdZzr, 64'd0};	// no write, no forward
			exStage2[l] = {regFilePkg::regIdZzr, 64'd0};
			exStage3[l] = {regFilePkg::regIdZzr, 64'd0};
		end
		for (int r = 0; r < regFilePkg::gprCount; r++)
		begin
			modelGpr[r] = '0;
		end
		repeat (resetCycles) @(posedge clock);
		#1 rstN = 1'b1;
		@(posedge clock);

		runTest("writeback", modeWrite, writeCycles);
		runTest("constants", modeConst, constCycles);
		runTest("forwarding", modeForward, forwardCycles);
		runTest("hold_flush", modeHoldFlush, holdFlushCycles);
		runTest("special_regs", modeSpecial, specialCycles);

		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
			testCount, checkCount, totalErrors,
			u_regFileTop.u_gprBankLvt.u_regFileProperties.failCount);
		if (totalErrors == 0
			&& u_regFileTop.u_gprBankLvt.u_regFileProperties.failCount == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: verilog.f
hw/regFilePkg.sv
hw/pipePkg.sv
hw/gprBankLvt.sv
hw/specialRegs.sv
hw/readPort.sv
hw/regFileTop.sv
dv/regFileProperties.sv
dv/regFileTb.sv
